/* host_link.f */
+incdir+rtl
rtl/host_link_pkg.sv
rtl/spi_byte_rx.sv
rtl/spi_msg_assembler.sv
rtl/spi_cmd_regs.sv
rtl/kbbuf_fifo.sv
rtl/reset_sequencer.sv
rtl/host_link_top.sv
bench/tb_host_link.sv

/* Bender.yml */
package:
  name: host_link

export_include_dirs:
  - rtl

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/host_link_pkg.sv
      - rtl/spi_byte_rx.sv
      - rtl/spi_msg_assembler.sv
      - rtl/spi_cmd_regs.sv
      - rtl/kbbuf_fifo.sv
      - rtl/reset_sequencer.sv
      - rtl/host_link_top.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - bench/tb_host_link.sv

/* bench/tb_host_link.sv */
`include "host_link_config.svh"

module tb_host_link;
    timeunit 1ns;
    timeprecision 1ps;
    import host_link_pkg::*;

    localparam int HALF     = 8;
    localparam int SETTLE   = 10;
    localparam int KB_DEPTH = 1 << `KBBUF_DEPTH_LOG2;
    localparam int HOLD     = `RESET_HOLD_CYCLES;

    // message counts per test group
    localparam int N_FULL    = 30;
    localparam int N_UNKNOWN = 6;
    localparam int N_LEN     = 20;
    localparam int N_KB      = 24;
    localparam int N_KB_OVF  = 20;
    localparam int N_RST     = 4;
    localparam int MSG_TOTAL = N_FULL + N_UNKNOWN + N_LEN + N_KB + N_KB_OVF + N_RST;
    localparam longint WATCHDOG_NS = longint'(MSG_TOTAL) * 100 * 16 * 40;

    logic        clk;
    logic        reset;
    logic        sclk;
    logic        mosi;
    logic        ssel_n;
    logic        kb_rd;
    logic [63:0] keys;
    logic [7:0]  hctrl1;
    logic [7:0]  hctrl2;
    logic [63:0] gamepad1;
    logic [63:0] gamepad2;
    kb_code_t    kb_rdata;
    logic        kb_empty;
    logic        sys_reset;
    logic        cold_boot;

    // reference model state
    logic [63:0] m_keys;
    logic [63:0] m_gp1;
    logic [63:0] m_gp2;
    logic [7:0]  m_hc1;
    logic [7:0]  m_hc2;
    kb_code_t    m_kb [$];
    logic [7:0]  msg_buf [0:15];
    int          errors;

    host_link_top UUT (
        .clk       (clk),
        .reset     (reset),
        .sclk      (sclk),
        .mosi      (mosi),
        .ssel_n    (ssel_n),
        .kb_rd     (kb_rd),
        .keys      (keys),
        .hctrl1    (hctrl1),
        .hctrl2    (hctrl2),
        .gamepad1  (gamepad1),
        .gamepad2  (gamepad2),
        .kb_rdata  (kb_rdata),
        .kb_empty  (kb_empty),
        .sys_reset (sys_reset),
        .cold_boot (cold_boot)
    );

    always #20 clk = ~clk;

    //////////////////////////////////////////////////////////////////////
    // result checks
    //////////////////////////////////////////////////////////////////////

    task automatic stop_run();
        errors++;
        $display("** FAIL **");
        $fatal(1, "testbench stopped on the first error");
    endtask

    task automatic check_word(input string name, input logic [63:0] exp, input logic [63:0] act);
        if (act !== exp) begin
            $display("FAILED %s expected %h actual %h", name, exp, act);
            stop_run();
        end
    endtask

    task automatic check_byte(input string name, input logic [7:0] exp, input logic [7:0] act);
        if (act !== exp) begin
            $display("FAILED %s expected %h actual %h", name, exp, act);
            stop_run();
        end
    endtask

    task automatic check_code(input string name, input kb_code_t exp, input kb_code_t act);
        if (act !== exp) begin
            $display("FAILED %s expected %h actual %h", name, exp, act);
            stop_run();
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("FAILED %s expected %b actual %b", name, exp, act);
            stop_run();
        end
    endtask

    // pulse length in cycles and the cold flag seen during it
    task automatic check_reset(input string name, input int exp_len, input logic exp_cold,
                               input int act_len, input logic act_cold);
        if (act_len != exp_len || act_cold !== exp_cold) begin
            $display("FAILED %s expected len %0d cold %b actual len %0d cold %b",
                     name, exp_len, exp_cold, act_len, act_cold);
            stop_run();
        end
    endtask

    task automatic compare_all(input string tag);
        @(negedge clk);
        check_word({tag, " keys"}, m_keys, keys);
        check_word({tag, " gamepad1"}, m_gp1, gamepad1);
        check_word({tag, " gamepad2"}, m_gp2, gamepad2);
        check_byte({tag, " hctrl1"}, m_hc1, hctrl1);
        check_byte({tag, " hctrl2"}, m_hc2, hctrl2);
        check_flag({tag, " kb_empty"}, m_kb.size() == 0, kb_empty);
        if (m_kb.size() != 0) begin
            check_code({tag, " kb_rdata"}, m_kb[0], kb_rdata);
        end
        check_flag({tag, " sys_reset"}, 1'b0, sys_reset);
    endtask

    //////////////////////////////////////////////////////////////////////
    // spi master and model
    //////////////////////////////////////////////////////////////////////

    // mode 0, data changes while sclk is low
    task automatic send_byte(input logic [7:0] b);
        int i;
        for (i = 7; i >= 0; i--) begin
            mosi <= b[i];
            repeat (HALF) @(posedge clk);
            sclk <= 1'b1;
            repeat (HALF) @(posedge clk);
            sclk <= 1'b0;
        end
    endtask

    task automatic send_msg(input logic [7:0] cmd, input int n);
        int i;
        @(posedge clk);
        ssel_n <= 1'b0;
        repeat (HALF) @(posedge clk);
        send_byte(cmd);
        for (i = 0; i < n; i++) begin
            send_byte(msg_buf[i]);
        end
        repeat (HALF) @(posedge clk);
        ssel_n <= 1'b1;
    endtask

    task automatic model_apply(input logic [7:0] cmd, input int n);
        logic [63:0] p;
        int          i;
        p = '0;
        // left aligned, at most eight data bytes
        for (i = 0; i < n && i < 8; i++) begin
            p[63 - 8 * i -: 8] = msg_buf[i];
        end
        case (cmd)
            CMD_SET_KEYB_MATRIX: m_keys = p;
            CMD_SET_HCTRL: {m_hc2, m_hc1} = p[63:48];
            CMD_WRITE_KBBUF16: begin
                if (m_kb.size() < KB_DEPTH) begin
                    m_kb.push_back(p[63:48]);
                end
            end
            CMD_WRITE_GAMEPAD1: m_gp1 = p;
            CMD_WRITE_GAMEPAD2: m_gp2 = p;
            default: begin
            end
        endcase
    endtask

    task automatic run_msg(input logic [7:0] cmd, input int n, input string tag);
        send_msg(cmd, n);
        model_apply(cmd, n);
        repeat (SETTLE) @(posedge clk);
        compare_all(tag);
    endtask

    task automatic fill_random(input int n);
        int i;
        for (i = 0; i < n; i++) begin
            msg_buf[i] = 8'($urandom_range(255));
        end
    endtask

    function automatic logic [7:0] unknown_code();
        logic [7:0] c;
        do begin
            c = 8'($urandom_range(255));
        end while (c inside {8'h01, 8'h10, 8'h11, 8'h13, 8'h14, 8'h15});
        return c;
    endfunction

    // checks the head before each kb_rd pulse, empty reads included
    task automatic read_codes(input int n, input string tag);
        int i;
        for (i = 0; i < n; i++) begin
            @(negedge clk);
            check_flag({tag, " kb_empty"}, m_kb.size() == 0, kb_empty);
            if (m_kb.size() != 0) begin
                check_code({tag, " kb_rdata"}, m_kb[0], kb_rdata);
            end
            @(posedge clk);
            kb_rd <= 1'b1;
            @(posedge clk);
            kb_rd <= 1'b0;
            if (m_kb.size() != 0) begin
                void'(m_kb.pop_front());
            end
        end
    endtask

    task automatic measure_reset(input logic exp_cold, input string tag);
        int   waited;
        int   len;
        logic cold_seen;
        waited = 0;
        len    = 0;
        @(negedge clk);
        while (!sys_reset) begin
            waited++;
            if (waited > 4 * HOLD) begin
                $display("sys_reset did not rise during %s", tag);
                stop_run();
            end
            @(negedge clk);
        end
        cold_seen = cold_boot;
        while (sys_reset) begin
            len++;
            if (cold_boot !== exp_cold) begin
                cold_seen = cold_boot;
            end
            if (len > 4 * HOLD) begin
                $display("sys_reset stayed high during %s", tag);
                stop_run();
            end
            @(negedge clk);
        end
        check_reset(tag, HOLD, exp_cold, len, cold_seen);
    endtask

    //////////////////////////////////////////////////////////////////////
    // test sequence
    //////////////////////////////////////////////////////////////////////

    initial begin
        int         i;
        int         n;
        logic [7:0] cmd;
        clk    = 1'b0;
        reset  = 1'b1;
        sclk   = 1'b0;
        mosi   = 1'b0;
        ssel_n = 1'b1;
        kb_rd  = 1'b0;
        errors = 0;
        void'($urandom(32'h4495));
        m_keys = '1;
        m_hc1  = 8'hff;
        m_hc2  = 8'hff;
        m_gp1  = '0;
        m_gp2  = '0;
        repeat (8) @(posedge clk);
        reset <= 1'b0;

        // power-on counts as cold
        measure_reset(1'b1, "power-on reset");
        compare_all("after reset");

        for (i = 0; i < N_FULL; i++) begin
            case ($urandom_range(2))
                0: cmd = CMD_SET_KEYB_MATRIX;
                1: cmd = CMD_WRITE_GAMEPAD1;
                default: cmd = CMD_WRITE_GAMEPAD2;
            endcase
            fill_random(8);
            run_msg(cmd, 8, "full write");
        end
        for (i = 0; i < N_UNKNOWN; i++) begin
            fill_random(8);
            run_msg(unknown_code(), $urandom_range(8), "unknown cmd");
        end

        // 1 to 12 data bytes
        for (i = 0; i < N_LEN; i++) begin
            case ($urandom_range(2))
                0: cmd = CMD_SET_HCTRL;
                1: cmd = CMD_WRITE_GAMEPAD1;
                default: cmd = CMD_WRITE_GAMEPAD2;
            endcase
            n = 1 + $urandom_range(11);
            fill_random(12);
            run_msg(cmd, n, "length");
        end

        for (i = 0; i < N_KB; i++) begin
            fill_random(3);
            run_msg(CMD_WRITE_KBBUF16, 1 + $urandom_range(2), "kbbuf write");
            read_codes($urandom_range(2), "kbbuf read");
        end
        read_codes(m_kb.size() + 2, "kbbuf drain");
        for (i = 0; i < N_KB_OVF; i++) begin
            fill_random(2);
            run_msg(CMD_WRITE_KBBUF16, 2, "kbbuf overflow");
        end
        read_codes(m_kb.size() + 1, "overflow drain");

        // bit 57 is bit 1 of the first data byte
        for (i = 0; i < N_RST; i++) begin
            n = 1 + $urandom_range(7);
            fill_random(8);
            msg_buf[0][1] = i[0];
            send_msg(CMD_RESET, n);
            model_apply(CMD_RESET, n);
            measure_reset(i[0], "reset cmd");
            compare_all("after reset cmd");
        end

        if (errors == 0) begin
            $display("** PASS **");
            $finish;
        end else begin
            stop_run();
        end
    end

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired, the test run took too long");
        stop_run();
    end

endmodule

/* rtl/host_link_top.sv */
module host_link_top (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    sclk,
    input  logic                    mosi,
    input  logic                    ssel_n,
    input  logic                    kb_rd,
    output logic [63:0]             keys,
    output logic [7:0]              hctrl1,
    output logic [7:0]              hctrl2,
    output logic [63:0]             gamepad1,
    output logic [63:0]             gamepad2,
    output host_link_pkg::kb_code_t kb_rdata,
    output logic                    kb_empty,
    output logic                    sys_reset,
    output logic                    cold_boot
);
    import host_link_pkg::*;

    // byte level
    logic       byte_valid;
    logic [7:0] byte_data;
    logic       msg_start;
    logic       msg_stop;

    // message level
    cmd_t       spi_cmd;
    payload_t   spi_rxdata;
    logic       spi_msg_end;

    // register block strobes
    logic       kb_wr_en;
    kb_code_t   kb_wr_data;
    logic       reset_req;
    logic       reset_req_cold;

    //////////////////////////////////////////////////////////////////////
    // spi front end
    //////////////////////////////////////////////////////////////////////

    spi_byte_rx u_byte_rx (
        .clk        (clk),
        .reset      (reset),
        .sclk       (sclk),
        .mosi       (mosi),
        .ssel_n     (ssel_n),
        .byte_valid (byte_valid),
        .byte_data  (byte_data),
        .msg_start  (msg_start),
        .msg_stop   (msg_stop)
    );

    spi_msg_assembler u_msg_asm (
        .clk         (clk),
        .reset       (reset),
        .byte_valid  (byte_valid),
        .byte_data   (byte_data),
        .msg_start   (msg_start),
        .msg_stop    (msg_stop),
        .spi_cmd     (spi_cmd),
        .spi_rxdata  (spi_rxdata),
        .spi_msg_end (spi_msg_end)
    );

    //////////////////////////////////////////////////////////////////////
    // command registers and their consumers
    //////////////////////////////////////////////////////////////////////

    spi_cmd_regs u_cmd_regs (
        .clk            (clk),
        .reset          (reset),
        .spi_msg_end    (spi_msg_end),
        .spi_cmd        (spi_cmd),
        .spi_rxdata     (spi_rxdata),
        .keys           (keys),
        .hctrl1         (hctrl1),
        .hctrl2         (hctrl2),
        .gamepad1       (gamepad1),
        .gamepad2       (gamepad2),
        .kb_wr_en       (kb_wr_en),
        .kb_wr_data     (kb_wr_data),
        .reset_req      (reset_req),
        .reset_req_cold (reset_req_cold)
    );

    kbbuf_fifo u_kbbuf (
        .clk        (clk),
        .reset      (reset),
        .kb_wr_en   (kb_wr_en),
        .kb_wr_data (kb_wr_data),
        .kb_rd      (kb_rd),
        .kb_rdata   (kb_rdata),
        .kb_empty   (kb_empty)
    );

    reset_sequencer u_rst_seq (
        .clk            (clk),
        .reset          (reset),
        .reset_req      (reset_req),
        .reset_req_cold (reset_req_cold),
        .sys_reset      (sys_reset),
        .cold_boot      (cold_boot)
    );

endmodule

/* rtl/reset_sequencer.sv */
`include "host_link_config.svh"

module reset_sequencer (
    input  logic clk,
    input  logic reset,
    input  logic reset_req,
    input  logic reset_req_cold,
    output logic sys_reset,
    output logic cold_boot
);

    localparam int CW = $clog2(`RESET_HOLD_CYCLES + 1);
    localparam logic [CW-1:0] HOLD = CW'(`RESET_HOLD_CYCLES);

    logic [CW-1:0] hold_cnt;
    logic          cold_flag;

    // power-on counts as a cold start
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            hold_cnt  <= HOLD;
            cold_flag <= 1'b1;
        end else if (reset_req) begin
            hold_cnt  <= HOLD;
            cold_flag <= reset_req_cold;
        end else if (hold_cnt != '0) begin
            hold_cnt  <= hold_cnt - 1'b1;
        end
    end

    // high for HOLD cycles after the load
    assign sys_reset = (hold_cnt != '0);
    assign cold_boot = sys_reset & cold_flag;

    // a request keeps sys_reset up through the whole hold window
    assert property (@(posedge clk) disable iff (reset)
        reset_req |-> ##`RESET_HOLD_CYCLES sys_reset);

endmodule

/* rtl/kbbuf_fifo.sv */
`include "host_link_config.svh"

module kbbuf_fifo (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    kb_wr_en,
    input  host_link_pkg::kb_code_t kb_wr_data,
    input  logic                    kb_rd,
    output host_link_pkg::kb_code_t kb_rdata,
    output logic                    kb_empty
);
    import host_link_pkg::*;

    localparam int AW    = `KBBUF_DEPTH_LOG2;
    localparam int DEPTH = 1 << AW;

    kb_code_t mem [DEPTH];

    // extra msb tells full from empty
    logic [AW:0] wr_ptr;
    logic [AW:0] rd_ptr;
    logic [AW:0] fill;
    logic        full;
    logic        do_wr;
    logic        do_rd;

    assign fill     = wr_ptr - rd_ptr;
    assign kb_empty = (wr_ptr == rd_ptr);
    assign full     = (wr_ptr[AW] != rd_ptr[AW]) && (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);

    assign do_wr    = kb_wr_en & ~full;
    assign do_rd    = kb_rd & ~kb_empty;

    //////////////////////////////////////////////////////////////////////
    // pointers
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (do_wr) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_rd) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (do_wr) begin
            mem[wr_ptr[AW-1:0]] <= kb_wr_data;
        end
    end

    // fall-through, head entry always on the output
    assign kb_rdata = mem[rd_ptr[AW-1:0]];

    assert property (@(posedge clk) disable iff (reset)
        fill <= (AW + 1)'(DEPTH));

endmodule

/* rtl/spi_cmd_regs.sv */
module spi_cmd_regs (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    spi_msg_end,
    input  host_link_pkg::cmd_t     spi_cmd,
    input  host_link_pkg::payload_t spi_rxdata,
    output logic [63:0]             keys,
    output logic [7:0]              hctrl1,
    output logic [7:0]              hctrl2,
    output logic [63:0]             gamepad1,
    output logic [63:0]             gamepad2,
    output logic                    kb_wr_en,
    output host_link_pkg::kb_code_t kb_wr_data,
    output logic                    reset_req,
    output logic                    reset_req_cold
);
    import host_link_pkg::*;

    //////////////////////////////////////////////////////////////////////
    // command decode
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            // keys and hand controllers are active low, idle released
            keys           <= '1;
            hctrl1         <= 8'hff;
            hctrl2         <= 8'hff;
            gamepad1       <= '0;
            gamepad2       <= '0;
            kb_wr_en       <= 1'b0;
            reset_req      <= 1'b0;
            reset_req_cold <= 1'b0;
        end else begin
            kb_wr_en       <= 1'b0;
            reset_req      <= 1'b0;
            reset_req_cold <= 1'b0;
            if (spi_msg_end) begin
                case (spi_cmd)
                    CMD_RESET: begin
                        reset_req      <= 1'b1;
                        reset_req_cold <= spi_rxdata.rst.cold;
                    end
                    CMD_SET_KEYB_MATRIX: begin
                        keys <= spi_rxdata.raw;
                    end
                    CMD_SET_HCTRL: begin
                        {hctrl2, hctrl1} <= spi_rxdata.word16.value;
                    end
                    CMD_WRITE_KBBUF16: begin
                        kb_wr_en <= 1'b1;
                    end
                    CMD_WRITE_GAMEPAD1: begin
                        gamepad1 <= spi_rxdata.raw;
                    end
                    CMD_WRITE_GAMEPAD2: begin
                        gamepad2 <= spi_rxdata.raw;
                    end
                    default: begin
                        // unknown code, nothing changes
                    end
                endcase
            end
        end
    end

    // keyboard code travels alongside kb_wr_en
    always_ff @(posedge clk) begin
        if (spi_msg_end && spi_cmd == CMD_WRITE_KBBUF16) begin
            kb_wr_data <= spi_rxdata.word16.value;
        end
    end

    // one message is one command, so at most one strobe per message
    assert property (@(posedge clk) disable iff (reset)
        (kb_wr_en || reset_req) |=> !(kb_wr_en || reset_req));

endmodule

/* rtl/spi_msg_assembler.sv */
`include "host_link_config.svh"

module spi_msg_assembler (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    byte_valid,
    input  logic [7:0]              byte_data,
    input  logic                    msg_start,
    input  logic                    msg_stop,
    output host_link_pkg::cmd_t     spi_cmd,
    output host_link_pkg::payload_t spi_rxdata,
    output logic                    spi_msg_end
);
    import host_link_pkg::*;

    // one count for the command byte plus one per payload byte
    localparam int CNT_W = $clog2(`PAYLOAD_BYTES + 2);
    localparam logic [CNT_W-1:0] CNT_MAX = CNT_W'(`PAYLOAD_BYTES + 1);

    logic [CNT_W-1:0] byte_cnt;
    logic             in_payload;

    assign in_payload = (byte_cnt != '0) && (byte_cnt <= CNT_W'(`PAYLOAD_BYTES));

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            byte_cnt    <= '0;
            spi_msg_end <= 1'b0;
        end else begin
            // a frame without a full command byte is silently dropped
            spi_msg_end <= msg_stop && (byte_cnt != '0);
            if (msg_start) begin
                byte_cnt <= '0;
            end else if (byte_valid && byte_cnt != CNT_MAX) begin
                // saturates, later bytes are ignored
                byte_cnt <= byte_cnt + 1'b1;
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // command and payload capture
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (msg_start) begin
            spi_rxdata.raw <= '0;
        end else if (byte_valid) begin
            if (byte_cnt == '0) begin
                spi_cmd <= cmd_t'(byte_data);
            end else if (in_payload) begin
                // byte n goes to [63-8(n-1) -: 8]
                spi_rxdata.raw[8 * (`PAYLOAD_BYTES - byte_cnt) +: 8] <= byte_data;
            end
        end
    end

endmodule

/* rtl/spi_byte_rx.sv */
module spi_byte_rx (
    input  logic       clk,
    input  logic       reset,
    input  logic       sclk,
    input  logic       mosi,
    input  logic       ssel_n,
    output logic       byte_valid,
    output logic [7:0] byte_data,
    output logic       msg_start,
    output logic       msg_stop
);

    // [1] is the synchronized level, [2] its previous value
    logic [2:0] sclk_sync;
    logic [2:0] ssel_sync;
    logic [1:0] mosi_sync;

    logic       sclk_rise;
    logic       ssel_fall;
    logic       ssel_rise;
    logic       shift_en;
    logic [2:0] bit_cnt;
    logic [6:0] shift_reg;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            sclk_sync <= 3'b000;
            ssel_sync <= 3'b111;
            mosi_sync <= 2'b00;
        end else begin
            sclk_sync <= {sclk_sync[1:0], sclk};
            ssel_sync <= {ssel_sync[1:0], ssel_n};
            mosi_sync <= {mosi_sync[0], mosi};
        end
    end

    assign sclk_rise = sclk_sync[1] & ~sclk_sync[2];
    assign ssel_fall = ~ssel_sync[1] & ssel_sync[2];
    assign ssel_rise = ssel_sync[1] & ~ssel_sync[2];

    // mode 0, sample on rising sclk while selected
    assign shift_en  = sclk_rise & ~ssel_sync[1];

    //////////////////////////////////////////////////////////////////////
    // edge stage, all pulses are registered here
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            msg_start  <= 1'b0;
            msg_stop   <= 1'b0;
            byte_valid <= 1'b0;
            bit_cnt    <= 3'd0;
        end else begin
            msg_start  <= ssel_fall;
            msg_stop   <= ssel_rise;
            byte_valid <= 1'b0;
            if (ssel_fall) begin
                bit_cnt <= 3'd0;
            end else if (shift_en) begin
                bit_cnt    <= bit_cnt + 3'd1;
                byte_valid <= (bit_cnt == 3'd7);
            end
        end
    end

    // msb first
    always_ff @(posedge clk) begin
        if (shift_en) begin
            shift_reg <= {shift_reg[5:0], mosi_sync[1]};
            if (bit_cnt == 3'd7) begin
                byte_data <= {shift_reg, mosi_sync[1]};
            end
        end
    end

    // bytes only complete inside a selected frame
    assert property (@(posedge clk) disable iff (reset)
        byte_valid |-> !ssel_sync[1]);

endmodule

/* rtl/host_link_pkg.sv */
package host_link_pkg;

    // command byte codes sent by the microcontroller
    typedef enum logic [7:0] {
        CMD_RESET           = 8'h01,
        CMD_SET_KEYB_MATRIX = 8'h10,
        CMD_SET_HCTRL       = 8'h11,
        CMD_WRITE_KBBUF16   = 8'h13,
        CMD_WRITE_GAMEPAD1  = 8'h14,
        CMD_WRITE_GAMEPAD2  = 8'h15
    } cmd_t;

    // keyboard scan code as queued for the core
    typedef logic [15:0] kb_code_t;

    // first two payload bytes as one value
    typedef struct packed {
        logic [15:0] value;
        logic [47:0] rest;
    } word16_view_t;

    // reset command flags in the first payload byte
    typedef struct packed {
        logic [5:0]  unused;
        logic        cold;
        logic        rsvd;
        logic [55:0] rest;
    } reset_view_t;

    // payload is left aligned, first data byte lands in [63:56]
    typedef union packed {
        logic [63:0]  raw;
        word16_view_t word16;
        reset_view_t  rst;
    } payload_t;

endpackage

/* rtl/host_link_config.svh */
`ifndef HOST_LINK_CONFIG_SVH
`define HOST_LINK_CONFIG_SVH

//////////////////////////////////////////////////////////////////////
// sizes
//////////////////////////////////////////////////////////////////////

// keyboard code buffer holds 2**KBBUF_DEPTH_LOG2 entries
`define KBBUF_DEPTH_LOG2 4

// data bytes after the command byte
`define PAYLOAD_BYTES 8

//////////////////////////////////////////////////////////////////////
// timing
//////////////////////////////////////////////////////////////////////

// length of the system reset pulse in clk cycles
`define RESET_HOLD_CYCLES 16

`endif
